// File: dv/tb_csr.sv
`timescale 1ns/1ps

module tb_csr;
    import csr_addr_pkg::*;

    localparam int OP_WRITE    = 0;
    localparam int OP_READ     = 1;
    localparam int OP_READ_OFF = 2; // read_en low on both ports
    localparam int OP_EXC      = 3;
    localparam int OP_ERTN     = 4;
    localparam int OP_TICK     = 5; // addr is the edge count, data the hwi level

    localparam logic [5:0] EXC_ECODE = 6'h0b;
    localparam logic [8:0] EXC_ESUB  = 9'h0a5;

    logic clk = 1'b0;
    logic rst;
    logic write_en;
    csr_addr_t write_addr;
    xlen_t write_data;
    logic [NUM_READ_PORTS-1:0] read_en;
    csr_addr_t read_addr [NUM_READ_PORTS];
    xlen_t read_data [NUM_READ_PORTS];
    logic is_exception;
    logic is_ertn;
    logic [5:0] ecode;
    logic [8:0] esubcode;
    xlen_t exception_pc;
    logic [7:0] hwi;
    xlen_t crmd, era, eentry, ecfg, estat;

    string     row_name [$];
    int        row_op [$];
    csr_addr_t row_addr [$];
    xlen_t     row_data [$];
    xlen_t     row_exp [$];

    // Reference state of the register file
    xlen_t m_crmd, m_prmd, m_ecfg, m_era, m_eentry, m_tval;
    xlen_t m_save [NUM_SAVE];
    logic [7:0] m_hwi;
    logic [5:0] m_ecode;
    logic [8:0] m_esub;
    logic [1:0] m_sw;
    logic m_ti;

    int unsigned seed = 85316;
    int errors = 0;
    int passes = 0;

    csr_top DUT (
        .clk, .rst, .write_en, .write_addr, .write_data, .read_en, .read_addr, .read_data,
        .is_exception, .is_ertn, .ecode, .esubcode, .exception_pc, .hwi,
        .crmd, .era, .eentry, .ecfg, .estat
    );

    always #5 clk = ~clk;

    function automatic xlen_t lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic xlen_t model_value(input csr_addr_t a);
        case (a)
            CSR_CRMD:   return m_crmd;
            CSR_PRMD:   return m_prmd;
            CSR_ECFG:   return m_ecfg;
            CSR_ESTAT:  return {1'b0, m_esub, m_ecode, 4'b0, m_ti, 1'b0, m_hwi, m_sw};
            CSR_ERA:    return m_era;
            CSR_EENTRY: return m_eentry;
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: return m_save[a[1:0]];
            CSR_TVAL:   return m_tval;
            default:    return '0; // CPUID, TICLR and holes
        endcase
    endfunction

    // Registers the pipeline also sees on the top-level outputs
    function automatic xlen_t direct_output(input csr_addr_t a);
        case (a)
            CSR_CRMD:   return crmd;
            CSR_ERA:    return era;
            CSR_EENTRY: return eentry;
            CSR_ECFG:   return ecfg;
            CSR_ESTAT:  return estat;
            default:    return '0;
        endcase
    endfunction

    task automatic add_row(input string n, input int op, input csr_addr_t a,
                           input xlen_t d, input xlen_t e);
        row_name.push_back(n);
        row_op.push_back(op);
        row_addr.push_back(a);
        row_data.push_back(d);
        row_exp.push_back(e);
    endtask

    task automatic add_write(input string n, input csr_addr_t a, input xlen_t d);
        case (a)
            CSR_CRMD:   m_crmd = d & 32'h0000_01FF;
            CSR_PRMD:   m_prmd = d & 32'h0000_0007;
            CSR_ECFG:   m_ecfg = d & 32'h0000_1BFF;
            CSR_ESTAT:  m_sw = d[1:0]; // Only the software bits take a write
            CSR_ERA:    m_era = d;
            CSR_EENTRY: m_eentry = d & 32'hFFFF_FFC0;
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: m_save[a[1:0]] = d;
            CSR_TCFG:   m_tval = d & ~32'h3;
            CSR_TICLR:  if (d[0]) m_ti = 1'b0;
            default: ;
        endcase
        add_row(n, OP_WRITE, a, d, '0);
    endtask

    task automatic add_read(input string n, input csr_addr_t a);
        add_row(n, OP_READ, a, '0, model_value(a));
    endtask

    task automatic add_tick(input string n, input csr_addr_t count, input logic [7:0] h);
        m_hwi = h;
        add_row(n, OP_TICK, count, {24'b0, h}, '0);
    endtask

    task automatic build_table();
        csr_addr_t wr_addrs [9];
        xlen_t pc;
        wr_addrs = '{CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_EENTRY, CSR_ERA,
                     CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3};
        m_crmd = 32'h8;
        m_prmd = '0;
        m_ecfg = '0;
        m_era = '0;
        m_eentry = '0;
        m_tval = '0;
        m_save = '{default: '0};
        m_hwi = '0;
        m_ecode = '0;
        m_esub = '0;
        m_sw = '0;
        m_ti = 1'b0;
        add_read("reset_crmd", CSR_CRMD);
        add_read("reset_prmd", CSR_PRMD);
        add_read("reset_era", CSR_ERA);
        add_read("reset_estat", CSR_ESTAT);
        add_read("reset_tval", CSR_TVAL);
        add_read("reset_save0", CSR_SAVE0);
        add_read("reset_save3", CSR_SAVE3);
        add_read("reset_cpuid", CSR_CPUID);
        add_read("reset_ticlr", CSR_TICLR);
        foreach (wr_addrs[i]) begin
            add_write($sformatf("mask_wr_%03h", wr_addrs[i]), wr_addrs[i], lcg_next());
            add_read($sformatf("mask_rd_%03h", wr_addrs[i]), wr_addrs[i]);
        end
        add_row("read_en_low", OP_READ_OFF, CSR_SAVE0, '0, '0);

        add_write("crmd_plv3_ie", CSR_CRMD, 32'hF); // DA kept
        pc = lcg_next() & ~32'h3;
        m_prmd = m_crmd & 32'h7;
        m_crmd = m_crmd & ~32'h7;
        m_era = pc;
        m_ecode = EXC_ECODE;
        m_esub = EXC_ESUB;
        add_row("exc_entry", OP_EXC, '0, pc, '0);
        add_read("exc_crmd", CSR_CRMD);
        add_read("exc_prmd", CSR_PRMD);
        add_read("exc_era", CSR_ERA);
        add_read("exc_estat", CSR_ESTAT);
        m_crmd = (m_crmd & ~32'h7) | m_prmd;
        add_row("ertn", OP_ERTN, '0, '0, '0);
        add_read("ertn_crmd", CSR_CRMD);

        add_tick("hwi_set", 14'd1, 8'hA5);
        add_read("hwi_estat", CSR_ESTAT);
        add_write("estat_sw_wr", CSR_ESTAT, lcg_next());
        add_read("estat_sw_rd", CSR_ESTAT);
        add_tick("hwi_clear", 14'd1, 8'h00);
        add_read("hwi_clear_rd", CSR_ESTAT);

        // Init 8 expires on the 9th edge, which the first read spends
        add_write("tcfg_oneshot", CSR_TCFG, 32'h9);
        add_tick("oneshot_count", 14'd8, 8'h00);
        add_read("oneshot_before", CSR_ESTAT);
        m_ti = 1'b1;
        m_tval = 32'hFFFF_FFFF;
        add_read("oneshot_irq", CSR_ESTAT);
        add_read("oneshot_tval", CSR_TVAL);
        add_write("ticlr", CSR_TICLR, 32'h1);
        add_read("ticlr_estat", CSR_ESTAT);

        add_write("tcfg_periodic", CSR_TCFG, 32'h7); // Init 4, periodic
        add_tick("periodic_count", 14'd4, 8'h00);
        m_tval = '0;
        add_read("periodic_zero", CSR_TVAL);
        m_ti = 1'b1;
        m_tval = 32'h4;
        add_read("periodic_reload", CSR_TVAL);
        add_read("periodic_irq", CSR_ESTAT);
        add_write("tcfg_stop", CSR_TCFG, 32'h4);
        add_tick("stopped", 14'd3, 8'h00);
        add_read("stopped_tval", CSR_TVAL);
    endtask

    task automatic apply_row(input int i);
        logic ok;
        xlen_t direct;
        ok = 1'b1;
        case (row_op[i])
            OP_WRITE: begin
                write_en = 1'b1;
                write_addr = row_addr[i];
                write_data = row_data[i];
                @(posedge clk);
                #1;
                write_en = 1'b0;
            end
            OP_READ, OP_READ_OFF: begin
                read_en = (row_op[i] == OP_READ) ? '1 : '0;
                read_addr[0] = row_addr[i];
                read_addr[1] = row_addr[i];
                #3; // Mid cycle, ports are combinational
                for (int p = 0; p < NUM_READ_PORTS; p++) begin
                    if (read_data[p] !== row_exp[i]) begin
                        $display("[FAIL] %s port %0d expected 0x%08h actual 0x%08h",
                                 row_name[i], p, row_exp[i], read_data[p]);
                        ok = 1'b0;
                    end
                end
                if (row_op[i] == OP_READ && row_addr[i] inside
                        {CSR_CRMD, CSR_ERA, CSR_EENTRY, CSR_ECFG, CSR_ESTAT}) begin
                    direct = direct_output(row_addr[i]);
                    if (direct !== row_exp[i]) begin
                        $display("[FAIL] %s output expected 0x%08h actual 0x%08h",
                                 row_name[i], row_exp[i], direct);
                        ok = 1'b0;
                    end
                end
                @(posedge clk);
                #1;
                read_en = '0;
            end
            OP_EXC: begin
                is_exception = 1'b1;
                ecode = EXC_ECODE;
                esubcode = EXC_ESUB;
                exception_pc = row_data[i];
                @(posedge clk);
                #1;
                is_exception = 1'b0;
            end
            OP_ERTN: begin
                is_ertn = 1'b1;
                @(posedge clk);
                #1;
                is_ertn = 1'b0;
            end
            default: begin
                hwi = row_data[i][7:0];
                repeat (row_addr[i]) @(posedge clk);
                #1;
            end
        endcase
        if (ok) begin
            passes++;
            $display("[PASS] %s", row_name[i]);
        end else begin
            errors++;
        end
    endtask

    initial begin
        #1;
        #(row_name.size() * 20 + 500);
        $display("Timeout, the watchdog expired before all rows were applied");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        write_en = 1'b0;
        write_addr = '0;
        write_data = '0;
        read_en = '0;
        read_addr = '{default: '0};
        is_exception = 1'b0;
        is_ertn = 1'b0;
        ecode = '0;
        esubcode = '0;
        exception_pc = '0;
        hwi = '0;
        build_table();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (row_name[i]) apply_row(i);
        $display("rows %0d, passed %0d, failed %0d", row_name.size(), passes, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/csr_addr_pkg.sv
package csr_addr_pkg;

    localparam int CSR_ADDR_W = 14;
    localparam int XLEN       = 32;

    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [XLEN-1:0]       xlen_t;

    // Exception control
    localparam csr_addr_t CSR_CRMD   = 14'h000;
    localparam csr_addr_t CSR_PRMD   = 14'h001;
    localparam csr_addr_t CSR_ECFG   = 14'h004;
    localparam csr_addr_t CSR_ESTAT  = 14'h005;
    localparam csr_addr_t CSR_ERA    = 14'h006;
    localparam csr_addr_t CSR_EENTRY = 14'h00C;

    localparam csr_addr_t CSR_CPUID  = 14'h020; // Reads as zero

    // Scratch registers for the exception handler
    localparam csr_addr_t CSR_SAVE0  = 14'h030;
    localparam csr_addr_t CSR_SAVE1  = 14'h031;
    localparam csr_addr_t CSR_SAVE2  = 14'h032;
    localparam csr_addr_t CSR_SAVE3  = 14'h033;

    // Timer
    localparam csr_addr_t CSR_TID    = 14'h040;
    localparam csr_addr_t CSR_TCFG   = 14'h041;
    localparam csr_addr_t CSR_TVAL   = 14'h042;
    localparam csr_addr_t CSR_TICLR  = 14'h044; // Write only, reads zero

    localparam int NUM_READ_PORTS = 2;
    localparam int NUM_SAVE       = 4;

endpackage

// File: rtl/csr_exc_pkg.sv
package csr_exc_pkg;

    typedef logic [5:0] ecode_t;
    typedef logic [8:0] esubcode_t;
    typedef logic [7:0] hwi_t;

    // PLV in 1:0 and IE in 2, same spot in CRMD and PRMD
    localparam int PLV_IE_W = 3;

    localparam csr_addr_pkg::xlen_t CRMD_RESET     = 32'h0000_0008; // DA=1
    localparam csr_addr_pkg::xlen_t CRMD_WMASK     = 32'h0000_01FF;
    localparam csr_addr_pkg::xlen_t PRMD_WMASK     = 32'h0000_0007;
    localparam csr_addr_pkg::xlen_t ECFG_WMASK     = 32'h0000_1BFF; // LIE 9:0, 12:11
    localparam csr_addr_pkg::xlen_t EENTRY_WMASK   = 32'hFFFF_FFC0;
    localparam csr_addr_pkg::xlen_t ESTAT_SW_WMASK = 32'h0000_0003;
    localparam csr_addr_pkg::xlen_t TVAL_ALL_ONES  = 32'hFFFF_FFFF;

    // ESTAT fields
    localparam int ESTAT_HWI_LSB   = 2;
    localparam int ESTAT_TI_BIT    = 11;
    localparam int ESTAT_ECODE_LSB = 16;
    localparam int ESTAT_ESUB_LSB  = 22;

    // TCFG fields, init value sits in 31:2
    localparam int TCFG_EN_BIT       = 0;
    localparam int TCFG_PERIODIC_BIT = 1;

endpackage

// File: rtl/csr_exc_regs.sv
`timescale 1ns/1ps

module csr_exc_regs (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               crmd_we,
    input  logic                               prmd_we,
    input  logic                               ecfg_we,
    input  logic                               estat_we,
    input  logic                               era_we,
    input  logic                               eentry_we,
    input  logic [csr_addr_pkg::NUM_SAVE-1:0]  save_we,
    input  csr_addr_pkg::xlen_t                write_data,
    input  logic                               is_exception,
    input  logic                               is_ertn,
    input  csr_exc_pkg::ecode_t                ecode,
    input  csr_exc_pkg::esubcode_t             esubcode,
    input  csr_addr_pkg::xlen_t                exception_pc,
    input  csr_exc_pkg::hwi_t                  hwi,
    input  logic                               timer_irq,
    output csr_addr_pkg::xlen_t                crmd,
    output csr_addr_pkg::xlen_t                prmd,
    output csr_addr_pkg::xlen_t                ecfg,
    output csr_addr_pkg::xlen_t                estat,
    output csr_addr_pkg::xlen_t                era,
    output csr_addr_pkg::xlen_t                eentry,
    output csr_addr_pkg::xlen_t                save [csr_addr_pkg::NUM_SAVE]
);
    import csr_addr_pkg::*;
    import csr_exc_pkg::*;

    xlen_t estat_q; // All of ESTAT except TI

    function automatic xlen_t merge(input xlen_t old_val, input xlen_t new_val,
                                    input xlen_t mask);
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            crmd <= CRMD_RESET;
        end else if (is_exception) begin
            crmd[PLV_IE_W-1:0] <= '0; // Kernel mode, interrupts off
        end else if (is_ertn) begin
            crmd[PLV_IE_W-1:0] <= prmd[PLV_IE_W-1:0];
        end else if (crmd_we) begin
            crmd <= merge(crmd, write_data, CRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prmd <= '0;
        end else if (is_exception) begin
            prmd[PLV_IE_W-1:0] <= crmd[PLV_IE_W-1:0];
        end else if (prmd_we) begin
            prmd <= merge(prmd, write_data, PRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ecfg   <= '0;
            eentry <= '0;
        end else begin
            if (ecfg_we) ecfg <= merge(ecfg, write_data, ECFG_WMASK);
            if (eentry_we) eentry <= merge(eentry, write_data, EENTRY_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            estat_q <= '0;
        end else begin
            if (is_exception) begin
                estat_q[ESTAT_ECODE_LSB +: $bits(ecode_t)]   <= ecode;
                estat_q[ESTAT_ESUB_LSB +: $bits(esubcode_t)] <= esubcode;
            end else if (estat_we) begin
                estat_q <= merge(estat_q, write_data, ESTAT_SW_WMASK);
            end
            estat_q[ESTAT_HWI_LSB +: $bits(hwi_t)] <= hwi; // Resampled every cycle
        end
    end

    // Timer pending bit is owned by the timer
    always_comb begin
        estat = estat_q;
        estat[ESTAT_TI_BIT] = timer_irq;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            era <= '0;
        end else if (is_exception) begin
            era <= exception_pc;
        end else if (era_we) begin
            era <= write_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            save <= '{default: '0};
        end else begin
            for (int i = 0; i < NUM_SAVE; i++) begin
                if (save_we[i]) save[i] <= write_data;
            end
        end
    end

    a_crmd_upper_zero: assert property (@(posedge clk) disable iff (rst)
        (crmd & ~CRMD_WMASK) == '0);

endmodule

// File: rtl/csr_read_port.sv
`timescale 1ns/1ps

module csr_read_port (
    input  logic                     rst,
    input  logic                     read_en,
    input  csr_addr_pkg::csr_addr_t  read_addr,
    input  csr_addr_pkg::xlen_t      crmd,
    input  csr_addr_pkg::xlen_t      prmd,
    input  csr_addr_pkg::xlen_t      ecfg,
    input  csr_addr_pkg::xlen_t      estat,
    input  csr_addr_pkg::xlen_t      era,
    input  csr_addr_pkg::xlen_t      eentry,
    input  csr_addr_pkg::xlen_t      save [csr_addr_pkg::NUM_SAVE],
    input  csr_addr_pkg::xlen_t      tid,
    input  csr_addr_pkg::xlen_t      tcfg,
    input  csr_addr_pkg::xlen_t      tval,
    output csr_addr_pkg::xlen_t      read_data
);
    import csr_addr_pkg::*;

    always_comb begin
        read_data = '0;
        if (!rst && read_en) begin
            case (read_addr)
                CSR_CRMD:   read_data = crmd;
                CSR_PRMD:   read_data = prmd;
                CSR_ECFG:   read_data = ecfg;
                CSR_ESTAT:  read_data = estat;
                CSR_ERA:    read_data = era;
                CSR_EENTRY: read_data = eentry;
                CSR_SAVE0:  read_data = save[0];
                CSR_SAVE1:  read_data = save[1];
                CSR_SAVE2:  read_data = save[2];
                CSR_SAVE3:  read_data = save[3];
                CSR_TID:    read_data = tid;
                CSR_TCFG:   read_data = tcfg;
                CSR_TVAL:   read_data = tval;
                CSR_CPUID, CSR_TICLR: read_data = '0; // Single core, no id
                default:    read_data = '0;
            endcase
        end
    end

endmodule

// File: rtl/csr_timer.sv
`timescale 1ns/1ps

module csr_timer (
    input  logic                clk,
    input  logic                rst,
    input  logic                tid_we,
    input  logic                tcfg_we,
    input  logic                ticlr_we,
    input  csr_addr_pkg::xlen_t write_data,
    output csr_addr_pkg::xlen_t tid,
    output csr_addr_pkg::xlen_t tcfg,
    output csr_addr_pkg::xlen_t tval,
    output logic                timer_irq
);
    import csr_exc_pkg::*;

    logic timer_en;
    logic expire;

    // Running counter at zero; a TCFG write in the same cycle takes over
    assign expire = timer_en && (tval == '0) && !tcfg_we;

    always_ff @(posedge clk) begin
        if (rst) begin
            tid  <= '0;
            tcfg <= '0;
        end else begin
            if (tid_we) tid <= write_data;
            if (tcfg_we) tcfg <= write_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tval     <= '0;
            timer_en <= 1'b0;
        end else if (tcfg_we) begin
            tval     <= {write_data[31:2], 2'b00};
            timer_en <= write_data[TCFG_EN_BIT];
        end else if (timer_en && tval != '0) begin
            tval <= tval - 32'd1;
        end else if (expire) begin
            if (tcfg[TCFG_PERIODIC_BIT]) begin
                tval <= {tcfg[31:2], 2'b00};
            end else begin
                tval     <= TVAL_ALL_ONES; // One-shot done, park the counter
                timer_en <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            timer_irq <= 1'b0;
        end else if (ticlr_we && write_data[0]) begin
            timer_irq <= 1'b0; // CLR
        end else if (expire) begin
            timer_irq <= 1'b1;
        end
    end

    a_tval_aligned: assert property (@(posedge clk) disable iff (rst)
        (tval[1:0] != 2'b00) |-> (timer_en || tval == TVAL_ALL_ONES));

endmodule

// File: rtl/csr_top.sv
`timescale 1ns/1ps

module csr_top (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    write_en,
    input  csr_addr_pkg::csr_addr_t                 write_addr,
    input  csr_addr_pkg::xlen_t                     write_data,
    input  logic [csr_addr_pkg::NUM_READ_PORTS-1:0] read_en,
    input  csr_addr_pkg::csr_addr_t                 read_addr [csr_addr_pkg::NUM_READ_PORTS],
    output csr_addr_pkg::xlen_t                     read_data [csr_addr_pkg::NUM_READ_PORTS],
    input  logic                                    is_exception,
    input  logic                                    is_ertn,
    input  csr_exc_pkg::ecode_t                     ecode,
    input  csr_exc_pkg::esubcode_t                  esubcode,
    input  csr_addr_pkg::xlen_t                     exception_pc,
    input  csr_exc_pkg::hwi_t                       hwi,
    output csr_addr_pkg::xlen_t                     crmd,
    output csr_addr_pkg::xlen_t                     era,
    output csr_addr_pkg::xlen_t                     eentry,
    output csr_addr_pkg::xlen_t                     ecfg,
    output csr_addr_pkg::xlen_t                     estat
);
    import csr_addr_pkg::*;

    logic crmd_we, prmd_we, ecfg_we, estat_we, era_we, eentry_we;
    logic tid_we, tcfg_we, ticlr_we;
    logic [NUM_SAVE-1:0] save_we;
    logic timer_irq;

    xlen_t prmd;
    xlen_t save [NUM_SAVE];
    xlen_t tid, tcfg, tval;

    csr_write_decode u_write_decode (
        .clk, .rst, .write_en, .write_addr,
        .crmd_we, .prmd_we, .ecfg_we, .estat_we, .era_we, .eentry_we,
        .tid_we, .tcfg_we, .ticlr_we, .save_we
    );

    csr_exc_regs u_exc_regs (
        .clk, .rst,
        .crmd_we, .prmd_we, .ecfg_we, .estat_we, .era_we, .eentry_we, .save_we,
        .write_data, .is_exception, .is_ertn, .ecode, .esubcode, .exception_pc,
        .hwi, .timer_irq,
        .crmd, .prmd, .ecfg, .estat, .era, .eentry, .save
    );

    csr_timer u_timer (
        .clk, .rst, .tid_we, .tcfg_we, .ticlr_we, .write_data,
        .tid, .tcfg, .tval, .timer_irq
    );

    // Both ports see the same register state, no bypass of same-cycle writes
    for (genvar p = 0; p < NUM_READ_PORTS; p++) begin : g_read
        csr_read_port u_read_port (
            .rst,
            .read_en   (read_en[p]),
            .read_addr (read_addr[p]),
            .crmd, .prmd, .ecfg, .estat, .era, .eentry, .save,
            .tid, .tcfg, .tval,
            .read_data (read_data[p])
        );
    end

endmodule

// File: rtl/csr_write_decode.sv
`timescale 1ns/1ps

module csr_write_decode (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               write_en,
    input  csr_addr_pkg::csr_addr_t            write_addr,
    output logic                               crmd_we,
    output logic                               prmd_we,
    output logic                               ecfg_we,
    output logic                               estat_we,
    output logic                               era_we,
    output logic                               eentry_we,
    output logic                               tid_we,
    output logic                               tcfg_we,
    output logic                               ticlr_we,
    output logic [csr_addr_pkg::NUM_SAVE-1:0]  save_we
);
    import csr_addr_pkg::*;

    assign crmd_we   = write_en && (write_addr == CSR_CRMD);
    assign prmd_we   = write_en && (write_addr == CSR_PRMD);
    assign ecfg_we   = write_en && (write_addr == CSR_ECFG);
    assign estat_we  = write_en && (write_addr == CSR_ESTAT);
    assign era_we    = write_en && (write_addr == CSR_ERA);
    assign eentry_we = write_en && (write_addr == CSR_EENTRY);
    assign save_we[0] = write_en && (write_addr == CSR_SAVE0);
    assign save_we[1] = write_en && (write_addr == CSR_SAVE1);
    assign save_we[2] = write_en && (write_addr == CSR_SAVE2);
    assign save_we[3] = write_en && (write_addr == CSR_SAVE3);
    assign tid_we    = write_en && (write_addr == CSR_TID);
    assign tcfg_we   = write_en && (write_addr == CSR_TCFG);
    assign ticlr_we  = write_en && (write_addr == CSR_TICLR);
    // CPUID and TVAL have no strobe, writes are dropped

    // Strobes feed two register modules; a single write must land in one place
    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        $onehot0({crmd_we, prmd_we, ecfg_we, estat_we, era_we, eentry_we,
                  save_we, tid_we, tcfg_we, ticlr_we}));

endmodule

// File: run.sh
#!/bin/sh
# Build and run the CSR testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -f vlog.f --top-module tb_csr -Mdir "$BUILD" -o tb_csr
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$BUILD/tb_csr" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
    exit 0
fi
exit 1

// File: vlog.f
rtl/csr_addr_pkg.sv
rtl/csr_exc_pkg.sv
rtl/csr_write_decode.sv
rtl/csr_exc_regs.sv
rtl/csr_timer.sv
rtl/csr_read_port.sv
rtl/csr_top.sv
dv/tb_csr.sv
